// ==== verilog/rvIsaPkg.sv ====
package rvIsaPkg;

    // architectural widths fixed by RV32I
    localparam int xLen = 32;
    localparam int regAddrW = 5;

    // instruction field widths
    localparam int opcodeW = 7;
    localparam int funct3W = 3;
    localparam int funct7W = 7;

    // major opcodes handled by the integer datapath
    typedef enum logic [opcodeW-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcodeE;

    // funct3 of OP and OP-IMM
    // SRL and SRA share F3_SR and differ in funct7
    typedef enum logic [funct3W-1:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3E;

    // funct7 values, alt selects SUB and SRA
    localparam logic [funct7W-1:0] f7Base = 7'b0000000;
    localparam logic [funct7W-1:0] f7Alt = 7'b0100000;

    // R-type field layout, also used to pick fields of I and U types
    typedef struct packed {
        logic [funct7W-1:0]  funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        funct3E              funct3;
        logic [regAddrW-1:0] rd;
        opcodeE              opcode;
    } instFieldsT;

endpackage

// ==== verilog/corePipePkg.sv ====
package corePipePkg;

    // ALU operations seen by the execute stage
    // PASSB forwards operand b unchanged, used for LUI
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        PASSB = 4'd10
    } aluOpE;

    // ID/EX pipeline register
    // operand b already holds the immediate for OP-IMM and LUI
    typedef struct packed {
        logic                              valid;
        aluOpE                             aluOp;
        logic [rvIsaPkg::regAddrW-1:0]     rd;
        logic [rvIsaPkg::xLen-1:0]         a;
        logic [rvIsaPkg::xLen-1:0]         b;
    } idExT;

    // register write record
    // used for EX forwarding, EX/WB register, write port and retire
    typedef struct packed {
        logic                              valid;
        logic [rvIsaPkg::regAddrW-1:0]     rd;
        logic [rvIsaPkg::xLen-1:0]         value;
    } wbT;

endpackage

// ==== verilog/regFile.sv ====
module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          rdy,
    input  corePipePkg::wbT               wrPort,
    input  logic [rvIsaPkg::regAddrW-1:0] rdAddrA,
    input  logic [rvIsaPkg::regAddrW-1:0] rdAddrB,
    output logic [rvIsaPkg::xLen-1:0]     rdDataA,
    output logic [rvIsaPkg::xLen-1:0]     rdDataB
);

    localparam int regCount = 2 ** rvIsaPkg::regAddrW;

    logic [rvIsaPkg::xLen-1:0] regs [regCount];

    // one read port: x0 first, then write-through, then the array
    function automatic logic [rvIsaPkg::xLen-1:0] readPort(
        input logic [rvIsaPkg::regAddrW-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wrPort.valid && (wrPort.rd == addr)) begin
            return wrPort.value;
        end else begin
            return regs[addr];
        end
    endfunction

    // write port, x0 is never stored
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy && wrPort.valid && (wrPort.rd != '0)) begin
            regs[wrPort.rd] <= wrPort.value;
        end
    end

    always_comb begin
        rdDataA = readPort(rdAddrA);
    end

    always_comb begin
        rdDataB = readPort(rdAddrB);
    end

endmodule

// ==== verilog/instDecoder.sv ====
module instDecoder (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          rdy,
    input  logic                          instValid,
    input  logic [rvIsaPkg::xLen-1:0]     instWord,
    input  logic [rvIsaPkg::xLen-1:0]     rdDataA,
    input  logic [rvIsaPkg::xLen-1:0]     rdDataB,
    input  corePipePkg::wbT               exFwd,
    output logic [rvIsaPkg::regAddrW-1:0] rdAddrA,
    output logic [rvIsaPkg::regAddrW-1:0] rdAddrB,
    output corePipePkg::idExT             idEx,
    output logic                          illegal
);

    rvIsaPkg::instFieldsT inst;
    logic [rvIsaPkg::xLen-1:0] immI;
    logic [rvIsaPkg::xLen-1:0] immU;
    logic [rvIsaPkg::xLen-1:0] srcA;
    logic [rvIsaPkg::xLen-1:0] srcB;
    logic [rvIsaPkg::xLen-1:0] opB;
    logic fwdA;
    logic fwdB;
    logic altFunc;
    logic legal;
    corePipePkg::aluOpE aluOp;
    corePipePkg::idExT idExNext;

    // funct3 plus the alt bit of funct7 to an ALU operation
    function automatic corePipePkg::aluOpE mapAluOp(
        input rvIsaPkg::funct3E f3,
        input logic             alt
    );
        case (f3)
            rvIsaPkg::F3_ADD:  return alt ? corePipePkg::SUB : corePipePkg::ADD;
            rvIsaPkg::F3_SLL:  return corePipePkg::SLL;
            rvIsaPkg::F3_SLT:  return corePipePkg::SLT;
            rvIsaPkg::F3_SLTU: return corePipePkg::SLTU;
            rvIsaPkg::F3_XOR:  return corePipePkg::XOR;
            rvIsaPkg::F3_SR:   return alt ? corePipePkg::SRA : corePipePkg::SRL;
            rvIsaPkg::F3_OR:   return corePipePkg::OR;
            default:           return corePipePkg::AND;
        endcase
    endfunction

    assign inst = rvIsaPkg::instFieldsT'(instWord);

    assign immI = {{(rvIsaPkg::xLen - 12){instWord[31]}}, instWord[31:20]};
    assign immU = {instWord[31:12], 12'b0};

    // register read addresses go straight to the register file
    assign rdAddrA = inst.rs1;
    assign rdAddrB = inst.rs2;

    // result of the instruction now in EX wins over the register file
    assign fwdA = exFwd.valid && (exFwd.rd == inst.rs1) && (inst.rs1 != '0);
    assign fwdB = exFwd.valid && (exFwd.rd == inst.rs2) && (inst.rs2 != '0);
    assign srcA = fwdA ? exFwd.value : rdDataA;
    assign srcB = fwdB ? exFwd.value : rdDataB;

    always_comb begin
        legal = 1'b0;
        altFunc = 1'b0;
        aluOp = corePipePkg::ADD;
        opB = srcB;
        case (inst.opcode)
            rvIsaPkg::OP: begin
                altFunc = (inst.funct7 == rvIsaPkg::f7Alt);
                // alt funct7 exists only for SUB and SRA
                legal = (inst.funct7 == rvIsaPkg::f7Base) ||
                        (altFunc && ((inst.funct3 == rvIsaPkg::F3_ADD) ||
                                     (inst.funct3 == rvIsaPkg::F3_SR)));
                aluOp = mapAluOp(inst.funct3, altFunc);
            end
            rvIsaPkg::OP_IMM: begin
                // upper bits are immediate except for the shifts
                altFunc = (inst.funct3 == rvIsaPkg::F3_SR) &&
                          (inst.funct7 == rvIsaPkg::f7Alt);
                case (inst.funct3)
                    rvIsaPkg::F3_SLL: legal = (inst.funct7 == rvIsaPkg::f7Base);
                    rvIsaPkg::F3_SR:  legal = (inst.funct7 == rvIsaPkg::f7Base) || altFunc;
                    default:          legal = 1'b1;
                endcase
                aluOp = mapAluOp(inst.funct3, altFunc);
                opB = immI;
            end
            rvIsaPkg::LUI: begin
                legal = 1'b1;
                aluOp = corePipePkg::PASSB;
                opB = immU;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        idExNext.valid = instValid && legal;
        idExNext.aluOp = aluOp;
        idExNext.rd = inst.rd;
        idExNext.a = srcA;
        idExNext.b = opB;
    end

    // ID/EX register, held while the core is frozen
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (rdy) begin
            idEx <= idExNext;
        end
    end

    // single-cycle pulse after an unknown encoding is accepted
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            illegal <= 1'b0;
        end else begin
            illegal <= instValid && rdy && !legal;
        end
    end

endmodule

// ==== verilog/aluExecute.sv ====
module aluExecute (
    input  logic              clk,
    input  logic              rstN,
    input  logic              rdy,
    input  corePipePkg::idExT idEx,
    output corePipePkg::wbT   exFwd,
    output corePipePkg::wbT   wb
);

    localparam int shamtW = $clog2(rvIsaPkg::xLen);

    logic [shamtW-1:0] shamt;
    logic [rvIsaPkg::xLen-1:0] result;
    logic ltSigned;
    logic ltUnsigned;

    // only the low bits of b count as shift amount
    assign shamt = idEx.b[shamtW-1:0];

    assign ltSigned = $signed(idEx.a) < $signed(idEx.b);
    assign ltUnsigned = idEx.a < idEx.b;

    always_comb begin
        case (idEx.aluOp)
            corePipePkg::ADD: begin
                result = idEx.a + idEx.b;
            end
            corePipePkg::SUB: begin
                result = idEx.a - idEx.b;
            end
            corePipePkg::SLL: begin
                result = idEx.a << shamt;
            end
            corePipePkg::SLT: begin
                result = {{(rvIsaPkg::xLen - 1){1'b0}}, ltSigned};
            end
            corePipePkg::SLTU: begin
                result = {{(rvIsaPkg::xLen - 1){1'b0}}, ltUnsigned};
            end
            corePipePkg::XOR: begin
                result = idEx.a ^ idEx.b;
            end
            corePipePkg::SRL: begin
                result = idEx.a >> shamt;
            end
            corePipePkg::SRA: begin
                // arithmetic shift keeps the sign of a
                result = $unsigned($signed(idEx.a) >>> shamt);
            end
            corePipePkg::OR: begin
                result = idEx.a | idEx.b;
            end
            corePipePkg::AND: begin
                result = idEx.a & idEx.b;
            end
            corePipePkg::PASSB: begin
                result = idEx.b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // forwarded back to decode in the same cycle
    always_comb begin
        exFwd.valid = idEx.valid;
        exFwd.rd = idEx.rd;
        exFwd.value = result;
    end

    // EX/WB register, drives the write port and retire
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb <= '0;
        end else if (rdy) begin
            wb <= exFwd;
        end
    end

endmodule

// ==== verilog/aluCore.sv ====
module aluCore (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      rdy,
    input  logic                      instValid,
    input  logic [rvIsaPkg::xLen-1:0] instWord,
    output corePipePkg::wbT           retire,
    output logic                      retireValid,
    output logic                      illegal
);

    logic [rvIsaPkg::regAddrW-1:0] rdAddrA;
    logic [rvIsaPkg::regAddrW-1:0] rdAddrB;
    logic [rvIsaPkg::xLen-1:0] rdDataA;
    logic [rvIsaPkg::xLen-1:0] rdDataB;
    corePipePkg::idExT idEx;
    corePipePkg::wbT exFwd;
    corePipePkg::wbT wb;

    instDecoder decoder_i (
        .clk       (clk),
        .rstN      (rstN),
        .rdy       (rdy),
        .instValid (instValid),
        .instWord  (instWord),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .exFwd     (exFwd),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .idEx      (idEx),
        .illegal   (illegal)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdy     (rdy),
        .wrPort  (wb),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    aluExecute execute_i (
        .clk   (clk),
        .rstN  (rstN),
        .rdy   (rdy),
        .idEx  (idEx),
        .exFwd (exFwd),
        .wb    (wb)
    );

    // a write commits only on an edge where rdy is high
    assign retire = wb;
    assign retireValid = wb.valid && rdy;

endmodule

// ==== test/coreTb.sv ====
module coreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int xLen = rvIsaPkg::xLen;
    localparam int addrW = rvIsaPkg::regAddrW;
    localparam int drainLimit = 50;

    logic clk;
    logic rstN;
    logic rdy;
    logic instValid;
    logic [xLen-1:0] instWord;
    corePipePkg::wbT retire;
    logic retireValid;
    logic illegal;

    // reference register state and expected retire order
    logic [xLen-1:0] regModel [32];
    corePipePkg::wbT expQ [$];
    logic [31:0] lfsrState = 32'h6486;
    logic illegalNow;
    logic expIllegal;
    logic stallEnable;
    int mismatchCount;
    int eventCount;
    int timeoutCount;

    aluCore dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .rdy         (rdy),
        .instValid   (instValid),
        .instWord    (instWord),
        .retire      (retire),
        .retireValid (retireValid),
        .illegal     (illegal)
    );

    always #5 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic lfsrBit();
        logic out;
        out = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (out) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrBit()};
        end
        return v;
    endfunction

    function automatic logic [addrW-1:0] randReg();
        logic [31:0] v;
        v = randBits(addrW);
        return v[addrW-1:0];
    endfunction

    // RV32I result of an OP or OP-IMM function
    function automatic logic [xLen-1:0] rv32Result(
        input rvIsaPkg::funct3E f3,
        input logic             alt,
        input logic [xLen-1:0]  a,
        input logic [xLen-1:0]  b
    );
        logic signed [xLen-1:0] sa;
        logic [4:0] sh;
        sa = a;
        sh = b[4:0];
        case (f3)
            rvIsaPkg::F3_ADD:  return alt ? a - b : a + b;
            rvIsaPkg::F3_SLL:  return a << sh;
            rvIsaPkg::F3_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            rvIsaPkg::F3_SLTU: return (a < b) ? 1 : 0;
            rvIsaPkg::F3_XOR:  return a ^ b;
            rvIsaPkg::F3_SR: begin
                if (alt) begin
                    return sa >>> sh;
                end
                return a >> sh;
            end
            rvIsaPkg::F3_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    task automatic checkRetire(input corePipePkg::wbT got);
        corePipePkg::wbT exp;
        if (expQ.size() == 0) begin
            $display("unexpected retire of x%0d at %0d ns", got.rd, $time);
            eventCount++;
            return;
        end
        exp = expQ.pop_front();
        if (got !== exp) begin
            $display("FAILED at %0d ns: retire x%0d = %h, expected x%0d = %h",
                     $time, got.rd, got.value, exp.rd, exp.value);
            mismatchCount++;
        end
    endtask

    task automatic checkIllegal(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: illegal = %b, expected %b", $time, got, exp);
            mismatchCount++;
        end
    endtask

    // sampled at the rising edge before the pipeline registers update
    always @(posedge clk) begin
        if (rstN) begin
            if (retireValid && !rdy) begin
                $display("FAILED at %0d ns: retireValid high while rdy is low", $time);
                mismatchCount++;
            end
            if (retireValid) begin
                checkRetire(retire);
            end
            checkIllegal(illegal, expIllegal);
            expIllegal = instValid && rdy && illegalNow;
        end
    end

    // offer one word and optionally freeze the core while it is held
    task automatic driveInst(input logic [xLen-1:0] word, input logic bad);
        int stall;
        @(negedge clk);
        instValid = 1'b1;
        instWord = word;
        illegalNow = bad;
        if (stallEnable && (randBits(2) == 0)) begin
            stall = 1 + randBits(3);
            rdy = 1'b0;
            repeat (stall) @(negedge clk);
            rdy = 1'b1;
        end
    endtask

    task automatic commitModel(input logic [addrW-1:0] rd, input logic [xLen-1:0] value);
        corePipePkg::wbT e;
        e.valid = 1'b1;
        e.rd = rd;
        e.value = value;
        expQ.push_back(e);
        if (rd != 0) begin
            regModel[rd] = value;
        end
    endtask

    task automatic issueOp(
        input rvIsaPkg::funct3E f3,
        input logic             alt,
        input logic [addrW-1:0] rd,
        input logic [addrW-1:0] rs1,
        input logic [addrW-1:0] rs2
    );
        logic [6:0] f7;
        f7 = alt ? rvIsaPkg::f7Alt : rvIsaPkg::f7Base;
        commitModel(rd, rv32Result(f3, alt, regModel[rs1], regModel[rs2]));
        driveInst({f7, rs2, rs1, f3, rd, rvIsaPkg::OP}, 1'b0);
    endtask

    task automatic issueImm(
        input rvIsaPkg::funct3E f3,
        input logic [addrW-1:0] rd,
        input logic [addrW-1:0] rs1,
        input logic [11:0]      imm
    );
        logic [xLen-1:0] b;
        logic alt;
        b = {{(xLen - 12){imm[11]}}, imm};
        alt = (f3 == rvIsaPkg::F3_SR) && imm[10];
        commitModel(rd, rv32Result(f3, alt, regModel[rs1], b));
        driveInst({imm, rs1, f3, rd, rvIsaPkg::OP_IMM}, 1'b0);
    endtask

    task automatic issueLui(input logic [addrW-1:0] rd, input logic [19:0] imm);
        commitModel(rd, {imm, 12'b0});
        driveInst({imm, rd, rvIsaPkg::LUI}, 1'b0);
    endtask

    // shift immediates carry funct7 in the upper bits
    function automatic logic [11:0] immFor(input rvIsaPkg::funct3E f3, input logic alt);
        logic [31:0] v;
        if (f3 == rvIsaPkg::F3_SLL) begin
            v = randBits(5);
            return {rvIsaPkg::f7Base, v[4:0]};
        end else if (f3 == rvIsaPkg::F3_SR) begin
            v = randBits(5);
            return {alt ? rvIsaPkg::f7Alt : rvIsaPkg::f7Base, v[4:0]};
        end
        v = randBits(12);
        return v[11:0];
    endfunction

    task automatic drain();
        int cycles;
        @(negedge clk);
        instValid = 1'b0;
        instWord = '0;
        illegalNow = 1'b0;
        cycles = 0;
        while ((expQ.size() != 0) && (cycles < drainLimit)) begin
            @(negedge clk);
            cycles++;
        end
        if (expQ.size() != 0) begin
            $display("timeout: %0d retires still missing after %0d cycles at %0d ns",
                     expQ.size(), drainLimit, $time);
            timeoutCount++;
            expQ.delete();
        end
    endtask

    // read every register back through x0 writes
    task automatic readAllRegs();
        for (int r = 1; r < 32; r++) begin
            issueImm(rvIsaPkg::F3_ADD, 0, r[addrW-1:0], 12'h000);
        end
        drain();
    endtask

    task automatic resetCore();
        rstN = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        if ((retireValid !== 1'b0) || (retire.valid !== 1'b0) || (illegal !== 1'b0)) begin
            $display("FAILED at %0d ns: outputs active after reset", $time);
            mismatchCount++;
        end
        rdy = 1'b1;
    endtask

    task automatic loadConstants();
        logic [31:0] v;
        for (int r = 1; r < 32; r++) begin
            v = randBits(32);
            issueLui(r[addrW-1:0], v[31:12]);
            issueImm(rvIsaPkg::F3_ADD, r[addrW-1:0], r[addrW-1:0], v[11:0]);
        end
        drain();
        readAllRegs();
    endtask

    task automatic sweepAluFunctions();
        rvIsaPkg::funct3E f3;
        for (int f = 0; f < 8; f++) begin
            f3 = rvIsaPkg::funct3E'(f[2:0]);
            for (int alt = 0; alt < 2; alt++) begin
                if ((alt == 0) || (f3 == rvIsaPkg::F3_ADD) || (f3 == rvIsaPkg::F3_SR)) begin
                    // sign corner cases for compares and arithmetic shift
                    issueLui(1, 20'h80000);
                    issueImm(rvIsaPkg::F3_ADD, 2, 0, 12'h001);
                    issueImm(rvIsaPkg::F3_ADD, 3, 0, 12'hfff);
                    issueOp(f3, alt[0], 4, 1, 2);
                    issueOp(f3, alt[0], 5, 3, 1);
                    repeat (6) begin
                        issueOp(f3, alt[0], randReg(), randReg(), randReg());
                        if ((alt == 0) || (f3 == rvIsaPkg::F3_SR)) begin
                            issueImm(f3, randReg(), randReg(), immFor(f3, alt[0]));
                        end
                    end
                end
            end
        end
        drain();
    endtask

    task automatic chainDependents();
        logic [addrW-1:0] prev;
        logic [addrW-1:0] prev2;
        logic [addrW-1:0] rd;
        logic [31:0] v;
        rvIsaPkg::funct3E f3;
        repeat (4) begin
            prev2 = randReg();
            prev = randReg();
            repeat (10) begin
                rd = randReg();
                if (rd == 0) begin
                    rd = 1;
                end
                v = randBits(4);
                f3 = rvIsaPkg::funct3E'(v[2:0]);
                // rs1 takes the EX path and rs2 the write-through path
                issueOp(f3, v[3] && ((f3 == rvIsaPkg::F3_ADD) || (f3 == rvIsaPkg::F3_SR)),
                        rd, prev, prev2);
                prev2 = prev;
                prev = rd;
            end
            issueImm(rvIsaPkg::F3_XOR, prev, prev, immFor(rvIsaPkg::F3_XOR, 1'b0));
        end
        drain();
    endtask

    task automatic writeZeroRegister();
        issueImm(rvIsaPkg::F3_ADD, 0, 1, 12'h7ff);
        issueOp(rvIsaPkg::F3_ADD, 1'b0, 6, 0, 0);
        issueOp(rvIsaPkg::F3_OR, 1'b0, 0, 2, 3);
        issueImm(rvIsaPkg::F3_ADD, 7, 0, 12'h123);
        issueLui(0, 20'habcde);
        issueOp(rvIsaPkg::F3_ADD, 1'b1, 8, 0, 0);
        drain();
        readAllRegs();
    endtask

    task automatic stallMidStream();
        stallEnable = 1'b1;
        repeat (40) begin
            issueOp(rvIsaPkg::F3_ADD, 1'b0, randReg(), randReg(), randReg());
            issueImm(rvIsaPkg::F3_SR, randReg(), randReg(), immFor(rvIsaPkg::F3_SR, 1'b1));
        end
        stallEnable = 1'b0;
        drain();
    endtask

    task automatic rejectIllegalOpcodes();
        logic [31:0] v;
        v = randBits(25);
        driveInst({v[24:0], 7'b0000011}, 1'b1);
        v = randBits(25);
        driveInst({v[24:0], 7'b1100011}, 1'b1);
        // funct7 outside the base set as used by the M extension
        driveInst({7'b0000001, 5'd2, 5'd1, rvIsaPkg::F3_ADD, 5'd9, rvIsaPkg::OP}, 1'b1);
        issueImm(rvIsaPkg::F3_ADD, 10, 9, 12'h001);
        drain();
        readAllRegs();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        rdy = 1'b0;
        instValid = 1'b0;
        instWord = '0;
        illegalNow = 1'b0;
        expIllegal = 1'b0;
        stallEnable = 1'b0;
        mismatchCount = 0;
        eventCount = 0;
        timeoutCount = 0;
        for (int r = 0; r < 32; r++) begin
            regModel[r] = '0;
        end

        resetCore();
        // registers read zero out of reset
        readAllRegs();
        loadConstants();
        sweepAluFunctions();
        chainDependents();
        writeZeroRegister();
        stallMidStream();
        rejectIllegalOpcodes();
        repeat (3) @(negedge clk);

        $display("errors: %0d mismatches, %0d unexpected events, %0d timeouts",
                 mismatchCount, eventCount, timeoutCount);
        if ((mismatchCount + eventCount + timeoutCount) == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/rvIsaPkg.sv
verilog/corePipePkg.sv
verilog/regFile.sv
verilog/instDecoder.sv
verilog/aluExecute.sv
verilog/aluCore.sv
test/coreTb.sv
